// ==== source/ioCtrl_params.svh ====
/*
 * I/O controller parameters
 * bus widths, I/O address decode and display geometry
 */
`ifndef IOCTRL_PARAMS_SVH
`define IOCTRL_PARAMS_SVH

// CPU side
`define IO_DATA_WIDTH      32
`define IO_ADDR_WIDTH      16
`define IO_ADDR_BIT        15   // set -> I/O space
`define IO_OFFSET_WIDTH    5    // register select bits

// lamp register
`define LAMP_WIDTH         8

// seven-segment display
`define DIGIT_COUNT        8
`define DIGITS_PER_GROUP   4
`define SEG_WIDTH          7

// clocks per digit slot, small for simulation
// a board build redefines this to get a visible refresh rate
`define SCAN_DIV           4

`endif

// ==== source/ioCtrlPkg.sv ====
/*
 * I/O controller types
 * register offsets, display mode and the bus and display structs
 */
`default_nettype none

`include "ioCtrl_params.svh"

package ioCtrlPkg;

    // I/O register offsets inside I/O space
    typedef enum logic [`IO_OFFSET_WIDTH-1:0] {
        SORT_START  = 5'd0,     // read: start button
        CE          = 5'd1,     // read: CE switch
        CP          = 5'd2,     // read: CP switch
        SORT_FINISH = 5'd3,     // write: stops the cycle counter
        LAMP        = 5'd4,
        LED_CTRL    = 5'd5,     // display mode select
        LED0        = 5'd8,
        LED1        = 5'd9,
        LED2        = 5'd10,
        LED3        = 5'd11,
        LED4        = 5'd12,
        LED5        = 5'd13,
        LED6        = 5'd14,
        LED7        = 5'd15
    } ioAddrT;

    typedef enum logic {
        USER_DIGITS = 1'b0,
        CYCLE_COUNT = 1'b1
    } dispModeT;

    // one CPU data access
    typedef struct packed {
        logic [`IO_ADDR_WIDTH-1:0] addr;
        logic [`IO_DATA_WIDTH-1:0] wrData;
        logic                      we;
    } cpuBusT;

    typedef struct packed {
        logic sortStart;
        logic ce;
        logic cp;
    } switchT;

    // digit 0 in the low nibble
    typedef logic [`DIGIT_COUNT-1:0][3:0] digitValT;

    // digit 0 in the low bits
    typedef logic [`DIGITS_PER_GROUP-1:0][`SEG_WIDTH-1:0] segGroupT;

endpackage

`default_nettype wire

// ==== source/ioRegFile.sv ====
/*
 * I/O register file
 * splits I/O from data memory space, holds the control registers and the cycle counter
 */
`timescale 1ns/1ps
`default_nettype none

`include "ioCtrl_params.svh"

module ioRegFile (
    input  logic                       clk,
    input  logic                       rst,
    input  ioCtrlPkg::cpuBusT          cpuBus,
    input  logic [`IO_DATA_WIDTH-1:0]  dmemRdData,
    input  ioCtrlPkg::switchT          sw,
    output logic                       dmemWe,
    output logic [`IO_DATA_WIDTH-1:0]  rdData,
    output logic [`LAMP_WIDTH-1:0]     lamp,
    output ioCtrlPkg::digitValT        dispVal
);

    logic                       isIo;
    ioCtrlPkg::ioAddrT          ioOffset;
    logic                       ioWrite;

    logic                       sortFinish;
    ioCtrlPkg::dispModeT        dispMode;
    ioCtrlPkg::digitValT        userDigits;
    ioCtrlPkg::switchT          swReg;      // sampled switch levels
    logic                       cycleRun;
    logic [`IO_DATA_WIDTH-1:0]  cycleCount;

    assign isIo     = cpuBus.addr[`IO_ADDR_BIT];
    assign ioOffset = ioCtrlPkg::ioAddrT'(cpuBus.addr[`IO_OFFSET_WIDTH-1:0]);
    assign ioWrite  = isIo & cpuBus.we;
    assign dmemWe   = cpuBus.we & ~isIo;    // memory never sees I/O writes

    // register writes
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sortFinish <= 1'b0;
            lamp       <= '0;
            dispMode   <= ioCtrlPkg::USER_DIGITS;
            userDigits <= '0;
        end else if (ioWrite) begin
            case (ioOffset)
                ioCtrlPkg::SORT_FINISH: sortFinish <= cpuBus.wrData[0];
                ioCtrlPkg::LAMP:        lamp       <= cpuBus.wrData[`LAMP_WIDTH-1:0];
                ioCtrlPkg::LED_CTRL:    dispMode   <= ioCtrlPkg::dispModeT'(cpuBus.wrData[0]);
                ioCtrlPkg::LED0, ioCtrlPkg::LED1, ioCtrlPkg::LED2, ioCtrlPkg::LED3,
                ioCtrlPkg::LED4, ioCtrlPkg::LED5, ioCtrlPkg::LED6, ioCtrlPkg::LED7:
                    userDigits[ioOffset[2:0]] <= cpuBus.wrData[3:0];   // low 3 bits = digit
                default: ;  // switch offsets are read only
            endcase
        end
    end

    // switches are levels, one cycle of sampling
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            swReg <= '0;
        end else begin
            swReg <= sw;
        end
    end

    // runs from the first start press until the finish flag is written
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cycleRun   <= 1'b0;
            cycleCount <= '0;
        end else if ((swReg.sortStart || cycleRun) && !sortFinish) begin
            cycleRun   <= 1'b1;
            cycleCount <= cycleCount + 1'b1;
        end
    end

    // CPU read path
    always_comb begin
        rdData = '0;
        if (isIo) begin
            case (ioOffset)
                ioCtrlPkg::SORT_START: rdData[0] = swReg.sortStart;
                ioCtrlPkg::CE:         rdData[0] = swReg.ce;
                ioCtrlPkg::CP:         rdData[0] = swReg.cp;
                default:               rdData    = '0;  // unmapped reads as zero
            endcase
        end else begin
            rdData = dmemRdData;
        end
    end

    assign dispVal = (dispMode == ioCtrlPkg::CYCLE_COUNT) ? ioCtrlPkg::digitValT'(cycleCount)
                                                          : userDigits;

    // counter stays at zero until it starts running
    cycleCountIdle: assert property (@(posedge clk) disable iff (!rst)
        !cycleRun |-> cycleCount == '0);

endmodule

`default_nettype wire

// ==== source/segEncoder.sv ====
/*
 * Seven-segment encoder
 * registered hex to segment patterns for all eight digits
 */
`timescale 1ns/1ps
`default_nettype none

`include "ioCtrl_params.svh"

module segEncoder (
    input  logic                 clk,
    input  logic                 rst,
    input  ioCtrlPkg::digitValT  dispVal,
    output ioCtrlPkg::segGroupT  segLo,
    output ioCtrlPkg::segGroupT  segHi
);

    // active high, bit 0 = segment a
    function automatic logic [`SEG_WIDTH-1:0] hexToSeg(input logic [3:0] hex);
        logic [`SEG_WIDTH-1:0] pattern;
        case (hex)
            4'h0: pattern = 7'h3F;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5B;
            4'h3: pattern = 7'h4F;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6D;
            4'h6: pattern = 7'h7D;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7F;
            4'h9: pattern = 7'h6F;
            4'hA: pattern = 7'h77;
            4'hB: pattern = 7'h7C;
            4'hC: pattern = 7'h39;
            4'hD: pattern = 7'h5E;
            4'hE: pattern = 7'h79;
            default: pattern = 7'h71;   // F
        endcase
        return pattern;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            segLo <= '0;
            segHi <= '0;
        end else begin
            for (int i = 0; i < `DIGITS_PER_GROUP; i++) begin
                segLo[i] <= hexToSeg(dispVal[i]);
                segHi[i] <= hexToSeg(dispVal[i + `DIGITS_PER_GROUP]);  // digits 4..7
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dynamicDisplay.sv ====
/*
 * Dynamic display scanner
 * multiplexes four segment patterns onto one digit bus with active-low gates
 */
`timescale 1ns/1ps
`default_nettype none

`include "ioCtrl_params.svh"

module dynamicDisplay #(
    parameter int scanDiv = `SCAN_DIV
) (
    input  logic                   clk,
    input  logic                   rst,
    input  ioCtrlPkg::segGroupT    segIn,
    output logic [`SEG_WIDTH-1:0]  seg,
    output logic [3:0]             gate
);

    localparam int CntWidth = (scanDiv > 1) ? $clog2(scanDiv) : 1;

    // one-hot digit select, bit 3 = digit 0
    localparam logic [3:0] SelDigit0 = 4'b1000;
    localparam logic [3:0] SelDigit1 = 4'b0100;
    localparam logic [3:0] SelDigit2 = 4'b0010;
    localparam logic [3:0] SelDigit3 = 4'b0001;

    logic [CntWidth-1:0] divCnt;
    logic                scanStrobe;
    logic [3:0]          sel;

    assign scanStrobe = (divCnt == CntWidth'(scanDiv - 1));

    // prescaler
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            divCnt <= '0;
        end else if (scanStrobe) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sel <= SelDigit0;
        end else if (scanStrobe) begin
            sel <= {sel[0], sel[3:1]};  // digit 0 -> 1 -> 2 -> 3 -> 0
        end
    end

    assign gate = ~sel;

    // seg lags gate by one cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            seg <= '0;
        end else begin
            case (sel)
                SelDigit0: seg <= segIn[0];
                SelDigit1: seg <= segIn[1];
                SelDigit2: seg <= segIn[2];
                SelDigit3: seg <= segIn[3];
                default:   seg <= '0;
            endcase
        end
    end

    // exactly one digit enabled at any time
    gateOneHot: assert property (@(posedge clk) disable iff (!rst) $onehot(~gate));

endmodule

`default_nettype wire

// ==== source/ioCtrl.sv ====
/*
 * I/O controller top
 * register file, segment encoder and two four-digit scanners
 */
`timescale 1ns/1ps
`default_nettype none

`include "ioCtrl_params.svh"

module ioCtrl (
    input  logic                       clk,
    input  logic                       rst,
    input  ioCtrlPkg::cpuBusT          cpuBus,
    input  logic [`IO_DATA_WIDTH-1:0]  dmemRdData,
    input  ioCtrlPkg::switchT          sw,
    output logic                       dmemWe,
    output logic [`IO_DATA_WIDTH-1:0]  rdData,
    output logic [`LAMP_WIDTH-1:0]     lamp,
    output logic [`SEG_WIDTH-1:0]      segLo,
    output logic [`SEG_WIDTH-1:0]      segHi,
    output logic [3:0]                 gateLo,
    output logic [3:0]                 gateHi
);

    ioCtrlPkg::digitValT dispVal;
    ioCtrlPkg::segGroupT segLoIn;   // digits 0..3
    ioCtrlPkg::segGroupT segHiIn;   // digits 4..7

    ioRegFile regFile (
        .clk        (clk),
        .rst        (rst),
        .cpuBus     (cpuBus),
        .dmemRdData (dmemRdData),
        .sw         (sw),
        .dmemWe     (dmemWe),
        .rdData     (rdData),
        .lamp       (lamp),
        .dispVal    (dispVal)
    );

    segEncoder encoder (
        .clk     (clk),
        .rst     (rst),
        .dispVal (dispVal),
        .segLo   (segLoIn),
        .segHi   (segHiIn)
    );

    dynamicDisplay scanLo (
        .clk   (clk),
        .rst   (rst),
        .segIn (segLoIn),
        .seg   (segLo),
        .gate  (gateLo)
    );

    dynamicDisplay scanHi (
        .clk   (clk),
        .rst   (rst),
        .segIn (segHiIn),
        .seg   (segHi),
        .gate  (gateHi)
    );

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
/*
 * Testbench clock
 * free-running 20 ns clock
 */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;  // 50 MHz

endmodule

`default_nettype wire

// ==== testbench/ioCtrlTb.sv ====
/*
 * I/O controller testbench
 * table-driven checks of the memory passthrough, switch reads, lamp and display
 */
`timescale 1ns/1ps
`default_nettype none

`include "ioCtrl_params.svh"

module ioCtrlTb;

    typedef enum {OP_MEM, OP_WRITE, OP_READ, OP_DIGIT, OP_COUNT} opT;

    typedef struct {
        string       name;
        opT          op;
        logic [15:0] addr;
        logic [31:0] data;
        logic [2:0]  sw;        // {sortStart, ce, cp}
        logic [31:0] expected;
    } rowT;

    // hex 0..F, bit 0 = segment a
    localparam logic [6:0] SegTable [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };
    localparam int GateTimeout = 8 * `SCAN_DIV;

    logic clk;
    logic rst;
    ioCtrlPkg::cpuBusT cpuBus;
    logic [31:0] dmemRdData;
    ioCtrlPkg::switchT sw;
    logic dmemWe;
    logic [31:0] rdData;
    logic [7:0] lamp;
    logic [6:0] segLo;
    logic [6:0] segHi;
    logic [3:0] gateLo;
    logic [3:0] gateHi;
    rowT tests[$];

    tbClock clockGen (.clk(clk));

    ioCtrl UUT (
        .clk(clk), .rst(rst), .cpuBus(cpuBus), .dmemRdData(dmemRdData), .sw(sw),
        .dmemWe(dmemWe), .rdData(rdData), .lamp(lamp),
        .segLo(segLo), .segHi(segHi), .gateLo(gateLo), .gateHi(gateHi)
    );

    function automatic logic [15:0] ioAddr(input logic [4:0] offset);
        return 16'h8000 | 16'(offset);
    endfunction

    task automatic addRow(input string name, input opT op, input logic [15:0] addr,
                          input logic [31:0] data, input logic [2:0] swVal,
                          input logic [31:0] expected);
        rowT r;
        r = '{name: name, op: op, addr: addr, data: data, sw: swVal, expected: expected};
        tests.push_back(r);
    endtask

    task automatic tick();  // inputs change 2 ns after the edge
        @(posedge clk);
        #2;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // returns the segment pattern shown while the gate points at digit d
    task automatic readDigit(input int d, output logic [6:0] pattern);
        int cnt;
        logic [3:0] g;
        logic [3:0] expGate;
        expGate = ~(4'b1000 >> (d % 4));    // active low, bit 3 = first digit
        for (cnt = 0; cnt < GateTimeout; cnt++) begin
            g = (d < 4) ? gateLo : gateHi;
            if (g[3 - (d % 4)] == 1'b0) break;
            tick();
        end
        if (cnt == GateTimeout) begin
            $display("timeout: the gate never selected digit %0d", d);
            $display("SOME TESTS FAILED");
            $fatal(1, "gate timeout");
        end
        checkValue($sformatf("gate digit%0d", d), 32'(expGate), 32'(g));
        tick();  // seg follows the gate one cycle later
        pattern = (d < 4) ? segLo : segHi;
    endtask

    task automatic applyRow(input rowT r);
        logic [6:0] first [8];
        logic [6:0] second [8];
        logic [6:0] pattern;
        logic nonZero;
        cpuBus.addr = r.addr;
        cpuBus.wrData = r.data;
        case (r.op)
            OP_MEM: begin
                cpuBus.we = 1'b0;
                dmemRdData = r.data;
                #1;
                checkValue({r.name, " dmemWe idle"}, 32'd0, 32'(dmemWe));
                checkValue(r.name, r.expected, rdData);
                tick();
                cpuBus.we = 1'b1;
                #1;
                checkValue({r.name, " dmemWe"}, 32'd1, 32'(dmemWe));
                tick();
                cpuBus.we = 1'b0;
            end
            OP_WRITE: begin
                cpuBus.we = 1'b1;
                #1;
                checkValue({r.name, " dmemWe"}, 32'd0, 32'(dmemWe));  // blocked in I/O space
                tick();
                cpuBus.we = 1'b0;
                if (r.addr[4:0] == 5'(ioCtrlPkg::LAMP)) checkValue(r.name, r.expected, 32'(lamp));
            end
            OP_READ: begin
                cpuBus.we = 1'b0;
                sw = r.sw;
                tick();
                checkValue(r.name, r.expected, rdData);
            end
            OP_DIGIT: begin
                readDigit(int'(r.addr[2:0]), pattern);
                checkValue(r.name, r.expected, 32'(pattern));
            end
            default: begin  // OP_COUNT
                tick();
                tick();
                nonZero = 1'b0;
                for (int d = 0; d < 8; d++) readDigit(d, first[d]);
                for (int d = 0; d < 8; d++) readDigit(d, second[d]);
                for (int d = 0; d < 8; d++) begin
                    checkValue($sformatf("%s digit%0d", r.name, d), 32'(first[d]),
                               32'(second[d]));
                    if (first[d] != SegTable[0]) nonZero = 1'b1;
                end
                checkValue({r.name, " nonzero"}, 32'd1, 32'(nonZero));
            end
        endcase
    endtask

    initial begin
        logic [31:0] memData;
        logic [31:0] lampData;
        logic [3:0] digits [8];
        void'($urandom(32'hec255ecc));
        memData = $urandom();
        lampData = $urandom();
        for (int i = 0; i < 8; i++) digits[i] = 4'($urandom());
        rst = 1'b0;
        cpuBus = '0;
        dmemRdData = '0;
        sw = '0;

        addRow("memAccess", OP_MEM, 16'h0124, memData, 3'b000, memData);
        addRow("swStart", OP_READ, ioAddr(ioCtrlPkg::SORT_START), 0, 3'b100, 32'd1);
        addRow("swCe", OP_READ, ioAddr(ioCtrlPkg::CE), 0, 3'b010, 32'd1);
        addRow("swCp", OP_READ, ioAddr(ioCtrlPkg::CP), 0, 3'b001, 32'd1);
        addRow("swLow", OP_READ, ioAddr(ioCtrlPkg::CE), 0, 3'b000, 32'd0);
        addRow("unmapped", OP_READ, ioAddr(5'd20), 0, 3'b111, 32'd0);
        addRow("lamp", OP_WRITE, ioAddr(ioCtrlPkg::LAMP), lampData, 3'b000, lampData & 32'hFF);
        for (int i = 0; i < 8; i++) begin
            addRow($sformatf("led%0d", i), OP_WRITE, ioAddr(5'(ioCtrlPkg::LED0) + 5'(i)),
                   32'(digits[i]), 3'b000, 0);
        end
        for (int i = 0; i < 8; i++) begin
            addRow($sformatf("digit%0d", i), OP_DIGIT, 16'(i), 0, 3'b000,
                   32'(SegTable[digits[i]]));
        end
        addRow("modeCount", OP_WRITE, ioAddr(ioCtrlPkg::LED_CTRL), 32'd1, 3'b000, 0);
        addRow("startPress", OP_READ, ioAddr(ioCtrlPkg::SORT_START), 0, 3'b100, 32'd1);
        addRow("startRelease", OP_READ, ioAddr(ioCtrlPkg::SORT_START), 0, 3'b000, 32'd0);
        addRow("finish", OP_WRITE, ioAddr(ioCtrlPkg::SORT_FINISH), 32'd1, 3'b000, 0);
        addRow("cycleCount", OP_COUNT, 16'h0000, 0, 3'b000, 0);

        repeat (5) @(posedge clk);  // reset held for 5 cycles
        #2;
        // both scanners parked on their first digit, segments dark
        checkValue("resetGateLo", 32'h7, 32'(gateLo));
        checkValue("resetGateHi", 32'h7, 32'(gateHi));
        checkValue("resetSegLo", 32'd0, 32'(segLo));
        checkValue("resetSegHi", 32'd0, 32'(segHi));
        rst = 1'b1;
        tick();
        foreach (tests[i]) applyRow(tests[i]);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/ioCtrlPkg.sv
source/ioRegFile.sv
source/segEncoder.sv
source/dynamicDisplay.sv
source/ioCtrl.sv
testbench/tbClock.sv
testbench/ioCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the I/O controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f all.f --top-module ioCtrlTb -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1
cat build.log sim.log 2> /dev/null
grep -q "ALL TESTS PASSED" sim.log 2> /dev/null && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }
